/* verilog/keypad_consts.svh */
`ifndef KEYPAD_CONSTS_SVH
`define KEYPAD_CONSTS_SVH

////////////////////////////////////////
// keypad geometry
////////////////////////////////////////

// number of push buttons on the panel
`define KP_BTN_N 4

// flops in the input synchroniser
`define KP_SYNC_STAGES 2

////////////////////////////////////////
// timing thresholds in clock cycles
////////////////////////////////////////

// stable cycles before a new level is accepted
`define KP_DEBOUNCE_CYCLES 4

// shortest debounced press that still counts
`define KP_PRESS_SHORT_MIN 3

// held cycles at which a press turns long
`define KP_PRESS_LONG 24

// duration counter width, saturates at all ones
`define KP_COUNT_BITS 8

// entries in the event fifo
`define KP_EVQ_DEPTH 4

`endif

/* verilog/press_pkg.sv */
package press_pkg;

    ////////////////////////////////////////
    // press classification of one button
    ////////////////////////////////////////

    // result of a completed press
    // none only shows up while no release is reported
    typedef enum logic [1:0] {
        // no classified press
        PRESS_NONE  = 2'd0,
        // held between the short minimum and the long threshold
        PRESS_SHORT = 2'd1,
        // held at least the long threshold
        PRESS_LONG  = 2'd2
    } press_kind_t;

    // code 2'd3 is never produced

endpackage

/* verilog/keypad_event_pkg.sv */
`include "keypad_consts.svh"

package keypad_event_pkg;

    ////////////////////////////////////////
    // event stream out of the keypad
    ////////////////////////////////////////

    // button number, wide enough for every button
    typedef logic [$clog2(`KP_BTN_N)-1:0] btn_index_t;

    // one fifo entry
    // button in the upper bits, kind in the lower bits
    typedef struct packed {
        btn_index_t             btn;
        press_pkg::press_kind_t kind;
    } key_event_t;

    // fifo fill level
    // one extra code so that a full fifo is representable
    typedef logic [$clog2(`KP_EVQ_DEPTH + 1)-1:0] evq_count_t;

endpackage

/* verilog/button_debounce.sv */
`timescale 1ns/100ps

`include "keypad_consts.svh"

module button_debounce (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [`KP_BTN_N-1:0] btn,
    output logic [`KP_BTN_N-1:0] btn_clean
);

    // stability counter width and its terminal value
    localparam int CNT_W = $clog2(`KP_DEBOUNCE_CYCLES + 1);
    localparam logic [CNT_W-1:0] CNT_EXPIRE = CNT_W'(`KP_DEBOUNCE_CYCLES - 1);

    ////////////////////////////////////////
    // input synchroniser
    ////////////////////////////////////////

    // one vector per flop stage
    logic [`KP_BTN_N-1:0] sync_q [`KP_SYNC_STAGES];
    logic [`KP_BTN_N-1:0] btn_sync;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int s = 0; s < `KP_SYNC_STAGES; s++) begin
                sync_q[s] <= '0;
            end
        end else begin
            sync_q[0] <= btn;
            // shift down the chain
            for (int s = 1; s < `KP_SYNC_STAGES; s++) begin
                sync_q[s] <= sync_q[s-1];
            end
        end
    end

    // last stage is safe to use
    assign btn_sync = sync_q[`KP_SYNC_STAGES-1];

    ////////////////////////////////////////
    // per button stability filter
    ////////////////////////////////////////

    logic [CNT_W-1:0] stab_cnt [`KP_BTN_N];

    for (genvar i = 0; i < `KP_BTN_N; i++) begin : g_filter
        always_ff @(posedge clk or negedge rst) begin
            if (!rst) begin
                stab_cnt[i]  <= '0;
                btn_clean[i] <= 1'b0;
            end else if (btn_sync[i] != btn_clean[i]) begin
                // differs again, accept on the last cycle
                if (stab_cnt[i] == CNT_EXPIRE) begin
                    btn_clean[i] <= btn_sync[i];
                    stab_cnt[i]  <= '0;
                end else begin
                    stab_cnt[i] <= stab_cnt[i] + 1'b1;
                end
            end else begin
                // agrees with accepted level, restart
                stab_cnt[i] <= '0;
            end
        end

        // level moves only after four synchronised samples at the new value
        a_clean_on_expire: assert property (
            @(posedge clk) disable iff (!rst)
            (btn_clean[i] != $past(btn_clean[i])) |->
                (($past(btn_sync[i], 1) == btn_clean[i]) &&
                 ($past(btn_sync[i], 2) == btn_clean[i]) &&
                 ($past(btn_sync[i], 3) == btn_clean[i]) &&
                 ($past(btn_sync[i], 4) == btn_clean[i]))
        );
    end

endmodule

/* verilog/press_classifier.sv */
`timescale 1ns/100ps

`include "keypad_consts.svh"

module press_classifier (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic [`KP_BTN_N-1:0]                   btn_clean,
    output logic [`KP_BTN_N-1:0]                   release_pulse,
    output press_pkg::press_kind_t [`KP_BTN_N-1:0] release_kind,
    output logic [`KP_BTN_N-1:0]                   held_long
);

    // thresholds at counter width
    localparam logic [`KP_COUNT_BITS-1:0] SHORT_TH = `KP_COUNT_BITS'(`KP_PRESS_SHORT_MIN);
    localparam logic [`KP_COUNT_BITS-1:0] LONG_TH  = `KP_COUNT_BITS'(`KP_PRESS_LONG);
    localparam logic [`KP_COUNT_BITS-1:0] CNT_MAX  = '1;

    ////////////////////////////////////////
    // one duration counter per button
    ////////////////////////////////////////

    for (genvar i = 0; i < `KP_BTN_N; i++) begin : g_btn
        logic [`KP_COUNT_BITS-1:0] dur_cnt;
        logic                      clean_d;
        logic                      fall;

        // high to low on the debounced level
        assign fall = clean_d & ~btn_clean[i];

        always_ff @(posedge clk or negedge rst) begin
            if (!rst) begin
                clean_d <= 1'b0;
            end else begin
                clean_d <= btn_clean[i];
            end
        end

        // count high cycles, stick at max
        always_ff @(posedge clk or negedge rst) begin
            if (!rst) begin
                dur_cnt <= '0;
            end else if (btn_clean[i]) begin
                if (dur_cnt != CNT_MAX) begin
                    dur_cnt <= dur_cnt + 1'b1;
                end
            end else begin
                dur_cnt <= '0;
            end
        end

        // release strobe, too short a press gives nothing
        always_ff @(posedge clk or negedge rst) begin
            if (!rst) begin
                release_pulse[i] <= 1'b0;
            end else begin
                release_pulse[i] <= fall && (dur_cnt >= SHORT_TH);
            end
        end

        // kind only matters alongside the strobe
        always_ff @(posedge clk) begin
            if (fall) begin
                release_kind[i] <= (dur_cnt >= LONG_TH) ? press_pkg::PRESS_LONG
                                                        : press_pkg::PRESS_SHORT;
            end
        end

        // live level, drops when the counter clears on release
        assign held_long[i] = (dur_cnt >= LONG_TH);

        // one strobe per release
        a_pulse_single: assert property (
            @(posedge clk) disable iff (!rst)
            release_pulse[i] |=> !release_pulse[i]
        );

        // a reported release always carries a class
        a_kind_valid: assert property (
            @(posedge clk) disable iff (!rst)
            release_pulse[i] |-> (release_kind[i] != press_pkg::PRESS_NONE)
        );
    end

endmodule

/* verilog/event_queue.sv */
`timescale 1ns/100ps

`include "keypad_consts.svh"

module event_queue (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic [`KP_BTN_N-1:0]                   release_pulse,
    input  press_pkg::press_kind_t [`KP_BTN_N-1:0] release_kind,
    input  logic                                   ev_pop,
    output logic                                   ev_valid,
    output keypad_event_pkg::btn_index_t           ev_btn,
    output press_pkg::press_kind_t                 ev_kind,
    output logic                                   ev_overflow
);

    localparam int PTR_W = $clog2(`KP_EVQ_DEPTH);
    localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(`KP_EVQ_DEPTH - 1);
    localparam keypad_event_pkg::evq_count_t DEPTH_CNT =
        keypad_event_pkg::evq_count_t'(`KP_EVQ_DEPTH);

    ////////////////////////////////////////
    // pending releases
    ////////////////////////////////////////

    logic [`KP_BTN_N-1:0]                   pending;
    press_pkg::press_kind_t [`KP_BTN_N-1:0] pend_kind;
    logic [`KP_BTN_N-1:0]                   grant_oh;
    logic [`KP_BTN_N-1:0]                   accept;
    logic [`KP_BTN_N-1:0]                   drop;
    keypad_event_pkg::btn_index_t           grant_idx;

    // fifo state
    keypad_event_pkg::key_event_t fifo_mem [`KP_EVQ_DEPTH];
    keypad_event_pkg::key_event_t new_ev;
    keypad_event_pkg::key_event_t head_ev;
    keypad_event_pkg::evq_count_t count;
    logic [PTR_W-1:0]             wr_ptr;
    logic [PTR_W-1:0]             rd_ptr;
    logic                         full;
    logic                         push;
    logic                         pop;

    assign full = (count == DEPTH_CNT);
    assign push = (|pending) && !full;
    assign pop  = ev_pop && ev_valid;

    // fixed priority, lowest index wins
    always_comb begin
        grant_idx = '0;
        for (int i = `KP_BTN_N - 1; i >= 0; i--) begin
            if (pending[i]) begin
                grant_idx = keypad_event_pkg::btn_index_t'(i);
            end
        end
        for (int i = 0; i < `KP_BTN_N; i++) begin
            grant_oh[i] = push && (grant_idx == keypad_event_pkg::btn_index_t'(i));
        end
    end

    // slot frees up when granted this cycle
    assign accept = release_pulse & (~pending | grant_oh);
    assign drop   = release_pulse & pending & ~grant_oh;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            pending <= '0;
        end else begin
            pending <= (pending & ~grant_oh) | accept;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < `KP_BTN_N; i++) begin
            if (accept[i]) begin
                pend_kind[i] <= release_kind[i];
            end
        end
    end

    // sticky until reset
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            ev_overflow <= 1'b0;
        end else if (|drop) begin
            ev_overflow <= 1'b1;
        end
    end

    ////////////////////////////////////////
    // circular fifo
    ////////////////////////////////////////

    assign new_ev.btn  = grant_idx;
    assign new_ev.kind = pend_kind[grant_idx];

    always_ff @(posedge clk) begin
        if (push) begin
            fifo_mem[wr_ptr] <= new_ev;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
            end
            // simultaneous push and pop leaves the count
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // head entry straight from the array
    assign head_ev  = fifo_mem[rd_ptr];
    assign ev_valid = (count != '0);
    assign ev_btn   = head_ev.btn;
    assign ev_kind  = head_ev.kind;

    a_count_bound: assert property (
        @(posedge clk) disable iff (!rst)
        count <= DEPTH_CNT
    );

    // a write never lands on an entry that is still unread
    a_no_write_full: assert property (
        @(posedge clk) disable iff (!rst)
        push |-> ((count == '0) || (wr_ptr != rd_ptr))
    );

endmodule

/* verilog/keypad_top.sv */
`timescale 1ns/100ps

`include "keypad_consts.svh"

module keypad_top (
    input  logic                         clk,
    input  logic                         rst,
    input  logic [`KP_BTN_N-1:0]         btn,
    input  logic                         ev_pop,
    output logic                         ev_valid,
    output keypad_event_pkg::btn_index_t ev_btn,
    output press_pkg::press_kind_t       ev_kind,
    output logic                         ev_overflow,
    output logic [`KP_BTN_N-1:0]         held_long
);

    ////////////////////////////////////////
    // inter stage wires
    ////////////////////////////////////////

    // debounced levels
    logic [`KP_BTN_N-1:0] btn_clean;

    // classified releases
    logic [`KP_BTN_N-1:0]                   release_pulse;
    press_pkg::press_kind_t [`KP_BTN_N-1:0] release_kind;

    // sync and bounce filter
    button_debounce debounce_i (
        .clk       (clk),
        .rst       (rst),
        .btn       (btn),
        .btn_clean (btn_clean)
    );

    // duration measure and short or long decision
    press_classifier classifier_i (
        .clk           (clk),
        .rst           (rst),
        .btn_clean     (btn_clean),
        .release_pulse (release_pulse),
        .release_kind  (release_kind),
        .held_long     (held_long)
    );

    // pending latch and event fifo
    event_queue queue_i (
        .clk           (clk),
        .rst           (rst),
        .release_pulse (release_pulse),
        .release_kind  (release_kind),
        .ev_pop        (ev_pop),
        .ev_valid      (ev_valid),
        .ev_btn        (ev_btn),
        .ev_kind       (ev_kind),
        .ev_overflow   (ev_overflow)
    );

endmodule

/* verification/keypad_tb.sv */
`timescale 1ns/100ps

`include "keypad_consts.svh"

module keypad_tb;

    localparam string TRACE_PATH = "verification/keypad_trace.txt";

    // dut inputs, known from time zero
    logic                 clk    = 1'b0;
    logic                 rst    = 1'b0;
    logic [`KP_BTN_N-1:0] btn    = '0;
    logic                 ev_pop = 1'b0;

    // dut outputs
    logic                         ev_valid;
    keypad_event_pkg::btn_index_t ev_btn;
    press_pkg::press_kind_t       ev_kind;
    logic                         ev_overflow;
    logic [`KP_BTN_N-1:0]         held_long;

    // trace text and the events still owed by the dut
    string                        trace_lines[$];
    keypad_event_pkg::key_event_t exp_q[$];

    logic consumer_on = 1'b0;
    int   pop_delay   = -1;
    int   cycle_count = 0;
    int   cycle_limit = 0;
    int   check_count = 0;
    int   err_count   = 0;

    // 40 ns period
    always #20 clk = ~clk;

    keypad_top dut_i (
        .clk         (clk),
        .rst         (rst),
        .btn         (btn),
        .ev_pop      (ev_pop),
        .ev_valid    (ev_valid),
        .ev_btn      (ev_btn),
        .ev_kind     (ev_kind),
        .ev_overflow (ev_overflow),
        .held_long   (held_long)
    );

    ////////////////////////////////////////
    // checking helpers
    ////////////////////////////////////////

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            $display("FAIL %0t %s got %0h expected %0h", $time, name, got, exp);
            err_count++;
        end
    endtask

    task automatic report_error(input string msg);
        $display("ERROR %0t %s", $time, msg);
        err_count++;
    endtask

    ////////////////////////////////////////
    // trace handling
    ////////////////////////////////////////

    task automatic load_trace(output bit ok);
        int    fd;
        int    r;
        string line;
        fd = $fopen(TRACE_PATH, "r");
        ok = (fd != 0);
        if (ok) begin
            while (!$feof(fd)) begin
                r = $fgets(line, fd);
                if (r > 0) begin
                    trace_lines.push_back(line);
                end
            end
            $fclose(fd);
        end
    endtask

    // sum of all hold lengths, sizes the timeout
    function automatic int hold_cycles_total();
        int    total;
        int    mask;
        int    n;
        string cmd;
        total = 0;
        foreach (trace_lines[i]) begin
            if ($sscanf(trace_lines[i], "%s %h %d", cmd, mask, n) == 3 && cmd == "D") begin
                total += n;
            end
        end
        return total;
    endfunction

    // raw level held for n rising edges
    task automatic hold_buttons(input int mask, input int n);
        repeat (n) begin
            @(posedge clk);
            btn <= mask[`KP_BTN_N-1:0];
        end
    endtask

    task automatic expect_event(input int b, input string ks);
        keypad_event_pkg::key_event_t e;
        e.btn = keypad_event_pkg::btn_index_t'(b);
        if (ks == "S") begin
            e.kind = press_pkg::PRESS_SHORT;
            exp_q.push_back(e);
        end else if (ks == "L") begin
            e.kind = press_pkg::PRESS_LONG;
            exp_q.push_back(e);
        end else begin
            report_error({"unknown press kind in trace: ", ks});
        end
    endtask

    task automatic run_line(input string line);
        string cmd;
        string arg;
        int    a;
        int    b;
        int    n;
        n = $sscanf(line, "%s", cmd);
        // blank lines and comments
        if (n < 1 || cmd == "#") begin
            return;
        end
        if (cmd == "D") begin
            if ($sscanf(line, "%s %h %d", cmd, a, b) == 3) begin
                hold_buttons(a, b);
            end else begin
                report_error("malformed hold line in trace");
            end
        end else if (cmd == "E") begin
            if ($sscanf(line, "%s %d %s", cmd, a, arg) == 3) begin
                expect_event(a, arg);
            end else begin
                report_error("malformed event line in trace");
            end
        end else if (cmd == "P") begin
            if ($sscanf(line, "%s %s", cmd, arg) == 2 && (arg == "on" || arg == "off")) begin
                consumer_on <= (arg == "on");
            end else begin
                report_error("malformed consumer line in trace");
            end
        end else if (cmd == "H") begin
            if ($sscanf(line, "%s %d", cmd, a) == 2) begin
                // sample away from the active edge
                @(negedge clk);
                check_value("held_long", 32'(held_long[a]), 32'd1);
            end else begin
                report_error("malformed held line in trace");
            end
        end else if (cmd == "O") begin
            if ($sscanf(line, "%s %d", cmd, a) == 2) begin
                @(negedge clk);
                check_value("ev_overflow", 32'(ev_overflow), 32'(a));
            end else begin
                report_error("malformed overflow line in trace");
            end
        end else begin
            report_error({"unknown trace command: ", cmd});
        end
    endtask

    ////////////////////////////////////////
    // consumer with random pop delay
    ////////////////////////////////////////

    // head compared in order against the expected list
    task automatic take_event();
        keypad_event_pkg::key_event_t e;
        if (exp_q.size() == 0) begin
            report_error($sformatf("button %0d delivered an event that was not expected",
                                   ev_btn));
        end else begin
            e = exp_q.pop_front();
            check_value("ev_btn", 32'(ev_btn), 32'(e.btn));
            check_value("ev_kind", 32'(ev_kind), 32'(e.kind));
        end
    endtask

    always @(posedge clk) begin
        if (!rst) begin
            ev_pop <= 1'b0;
            pop_delay = -1;
        end else if (ev_pop) begin
            // head leaves on this edge
            ev_pop <= 1'b0;
            pop_delay = -1;
        end else if (consumer_on && ev_valid) begin
            if (pop_delay < 0) begin
                pop_delay = int'($urandom_range(3, 0));
            end
            if (pop_delay == 0) begin
                take_event();
                ev_pop <= 1'b1;
            end else begin
                pop_delay--;
            end
        end
    end

    ////////////////////////////////////////
    // timeout
    ////////////////////////////////////////

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("timeout after %0d cycles, %0d expected events were never delivered",
                     cycle_count, exp_q.size());
            $display("checks %0d, errors %0d", check_count, err_count + 1);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    ////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////

    initial begin
        bit ok;
        int idle;
        void'($urandom(60437));
        load_trace(ok);
        if (!ok) begin
            $display("could not open the trace file %s", TRACE_PATH);
            $display("SOME TESTS FAILED");
            $finish;
        end else begin
            cycle_limit = 2 * hold_cycles_total() + 200;
            repeat (8) @(posedge clk);
            rst <= 1'b1;
            // quiet outputs out of reset
            @(negedge clk);
            check_value("ev_valid", 32'(ev_valid), 32'd0);
            check_value("ev_overflow", 32'(ev_overflow), 32'd0);
            check_value("held_long", 32'(held_long), 32'd0);
            foreach (trace_lines[i]) begin
                run_line(trace_lines[i]);
            end
            // drain what is still queued
            idle = 0;
            while (exp_q.size() != 0 && idle < 100) begin
                @(posedge clk);
                idle++;
            end
            if (exp_q.size() != 0) begin
                report_error($sformatf("%0d expected events were never delivered",
                                       exp_q.size()));
            end
            $display("checks %0d, errors %0d", check_count, err_count);
            if (err_count == 0) begin
                $display("ALL TESTS PASSED");
            end else begin
                $display("SOME TESTS FAILED");
            end
            $finish;
        end
    end

endmodule

/* verification/keypad_trace.txt */
# columns: D <mask hex> <cycles> | E <btn> <S|L> | P <on|off> | H <btn> | O <0|1>
# D holds raw buttons, E expects an event, P switches the consumer, H and O check levels
P on
D 0 10
O 0
# bounce shorter than the debounce window
D 1 2
D 0 1
D 1 3
D 0 2
D 4 1
D 0 20
# short press on button 2
E 2 S
D 4 10
D 0 30
# long press on button 3
E 3 L
D 8 40
H 3
D 0 30
# buttons 3 1 0 released together
E 0 S
E 1 S
E 3 S
D b 10
D 0 30
# back pressure with six releases
P off
E 0 S
D 1 8
D 0 12
E 1 S
D 2 8
D 0 12
E 2 S
D 4 8
D 0 12
E 3 S
D 8 8
D 0 12
E 0 L
D 1 30
D 0 12
E 1 S
D 2 8
D 0 20
P on
D 0 30
O 0
# fill the fifo then release button 2 twice
P off
E 0 S
D 1 8
D 0 12
E 1 S
D 2 8
D 0 12
E 3 S
D 8 8
D 0 12
E 0 S
D 1 8
D 0 12
E 2 S
D 4 8
D 0 12
D 4 30
D 0 12
O 1
P on
D 0 40

/* verilog.f */
+incdir+verilog
verilog/press_pkg.sv
verilog/keypad_event_pkg.sv
verilog/button_debounce.sv
verilog/press_classifier.sv
verilog/event_queue.sv
verilog/keypad_top.sv
verification/keypad_tb.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := keypad_tb
FILELIST  := verilog.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "SOME TESTS FAILED" $(LOG); then \
		echo "simulation reported failure"; \
		exit 1; \
	fi
	@grep -q "ALL TESTS PASSED" $(LOG) || { echo "no pass message in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
